/* verilog/mont_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Montgomery exponentiator shared definitions
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package mont_pkg;

    localparam int WORD_WIDTH = 16;   // bits per operand word
    localparam int SEL_WIDTH  = 2;

    // operand select codes for the A and B inputs of a MonPro
    localparam logic [SEL_WIDTH-1:0] SEL_M_BAR = 2'd0;   // holds m until transformed
    localparam logic [SEL_WIDTH-1:0] SEL_C_BAR = 2'd1;
    localparam logic [SEL_WIDTH-1:0] SEL_T     = 2'd2;   // R^2 mod n
    localparam logic [SEL_WIDTH-1:0] SEL_ONE   = 2'd3;   // the integer 1

    // multiply-add result, whole or split into carry and sum words
    typedef union packed {
        logic [2*WORD_WIDTH-1:0] full;
        struct packed {
            logic [WORD_WIDTH-1:0] carry;
            logic [WORD_WIDTH-1:0] sum;
        } parts;
    } mul_add_result_u;

endpackage

`default_nettype wire

/* verilog/mont_ifs.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MonPro command and operand access interfaces
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

interface mm_cmd_if;
    import mont_pkg::*;

    logic                 start;   // one cycle, engine idle only
    logic [SEL_WIDTH-1:0] a_sel;
    logic [SEL_WIDTH-1:0] b_sel;
    logic                 done;    // result already in its bank

    modport ctrl (
        output start,
        output a_sel,
        output b_sel,
        input  done
    );

    modport engine (
        input  start,
        input  a_sel,
        input  b_sel,
        output done
    );
endinterface

interface operand_if #(
    parameter int NUM_WORDS = 2
);
    import mont_pkg::*;

    logic [SEL_WIDTH-1:0]         a_sel;
    logic [SEL_WIDTH-1:0]         b_sel;
    logic [$clog2(NUM_WORDS)-1:0] a_idx;
    logic [$clog2(NUM_WORDS)-1:0] b_idx;
    logic [$clog2(NUM_WORDS)-1:0] n_idx;
    logic                         wr_en;
    logic [$clog2(NUM_WORDS)-1:0] wr_idx;
    logic [WORD_WIDTH-1:0]        wr_word;
    logic [WORD_WIDTH-1:0]        a_word;    // combinational read data
    logic [WORD_WIDTH-1:0]        b_word;
    logic [WORD_WIDTH-1:0]        n_word;
    logic [WORD_WIDTH-1:0]        nprime0;

    modport store (
        input  a_sel, b_sel, a_idx, b_idx, n_idx, wr_en, wr_idx, wr_word,
        output a_word, b_word, n_word, nprime0
    );

    modport engine (
        output a_sel, b_sel, a_idx, b_idx, n_idx, wr_en, wr_idx, wr_word,
        input  a_word, b_word, n_word, nprime0
    );
endinterface

`default_nettype wire

/* verilog/mul_add_unit.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Registered word multiply-add
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module mul_add_unit (
    input  logic                            clk,
    input  logic [mont_pkg::WORD_WIDTH-1:0] x,
    input  logic [mont_pkg::WORD_WIDTH-1:0] y,
    input  logic [mont_pkg::WORD_WIDTH-1:0] z,
    input  logic [mont_pkg::WORD_WIDTH-1:0] carry_in,
    output mont_pkg::mul_add_result_u       result
);
    import mont_pkg::*;

    localparam int DW = 2 * WORD_WIDTH;

    // worst case (2^w-1)^2 + 2(2^w-1) still fits in two words
    always_ff @(posedge clk) begin
        result.full <= DW'(x) * DW'(y) + DW'(z) + DW'(carry_in);
    end

endmodule

`default_nettype wire

/* verilog/operand_store.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Operand word banks
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module operand_store #(
    parameter int NUM_WORDS = 2
) (
    input  logic                                                clk,
    input  logic                                                reset,
    input  logic                                                load_valid,
    input  logic                                                load_ready,
    input  logic [mont_pkg::WORD_WIDTH-1:0]                     m_word,
    input  logic [mont_pkg::WORD_WIDTH-1:0]                     e_word,
    input  logic [mont_pkg::WORD_WIDTH-1:0]                     n_word,
    input  logic [mont_pkg::WORD_WIDTH-1:0]                     r_word,
    input  logic [mont_pkg::WORD_WIDTH-1:0]                     t_word,
    input  logic [mont_pkg::WORD_WIDTH-1:0]                     nprime0,
    input  logic                                                copy_r,
    input  logic [$clog2(NUM_WORDS*mont_pkg::WORD_WIDTH)-1:0]   e_bit_idx,
    output logic                                                e_bit,
    input  logic [$clog2(NUM_WORDS)-1:0]                        res_idx,
    output logic [mont_pkg::WORD_WIDTH-1:0]                     c_bar_word,
    operand_if.store                                            ops
);
    import mont_pkg::*;

    localparam int IDX_W = $clog2(NUM_WORDS);
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(NUM_WORDS - 1);

    logic [WORD_WIDTH-1:0]           m_bar  [NUM_WORDS];   // m, then m * R mod n
    logic [WORD_WIDTH-1:0]           c_bar  [NUM_WORDS];
    logic [WORD_WIDTH-1:0]           n_bank [NUM_WORDS];
    logic [WORD_WIDTH-1:0]           r_bank [NUM_WORDS];
    logic [WORD_WIDTH-1:0]           t_bank [NUM_WORDS];
    logic [NUM_WORDS*WORD_WIDTH-1:0] e_bits;               // flat for bit scan
    logic [WORD_WIDTH-1:0]           nprime0_q;
    logic [IDX_W-1:0]                load_idx;
    logic                            load_fire;
    logic                            wr_m_bar;

    assign load_fire = load_valid && load_ready;
    assign wr_m_bar  = (ops.a_sel == SEL_M_BAR) && (ops.b_sel == SEL_T);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            load_idx <= '0;
        end else if (load_fire) begin
            load_idx <= (load_idx == LAST_IDX) ? '0 : load_idx + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (load_fire) begin
            m_bar[load_idx]  <= m_word;
            n_bank[load_idx] <= n_word;
            r_bank[load_idx] <= r_word;
            t_bank[load_idx] <= t_word;
            e_bits[load_idx*WORD_WIDTH +: WORD_WIDTH] <= e_word;
            if (load_idx == '0) begin
                nprime0_q <= nprime0;   // only word 0 of n' is needed
            end
        end
        if (copy_r) begin
            c_bar <= r_bank;            // c_bar starts as 1 in Montgomery form
        end
        if (ops.wr_en) begin
            if (wr_m_bar) begin
                m_bar[ops.wr_idx] <= ops.wr_word;
            end else begin
                c_bar[ops.wr_idx] <= ops.wr_word;
            end
        end
    end

    function automatic logic [WORD_WIDTH-1:0] read_sel(input logic [SEL_WIDTH-1:0] sel,
                                                      input logic [IDX_W-1:0]     idx);
        case (sel)
            SEL_M_BAR: read_sel = m_bar[idx];
            SEL_C_BAR: read_sel = c_bar[idx];
            SEL_T:     read_sel = t_bank[idx];
            default:   read_sel = (idx == '0) ? WORD_WIDTH'(1) : '0;
        endcase
    endfunction

    always_comb begin
        ops.a_word = read_sel(ops.a_sel, ops.a_idx);
        ops.b_word = read_sel(ops.b_sel, ops.b_idx);
    end

    assign ops.n_word  = n_bank[ops.n_idx];
    assign ops.nprime0 = nprime0_q;
    assign e_bit       = e_bits[e_bit_idx];
    assign c_bar_word  = c_bar[res_idx];

endmodule

`default_nettype wire

/* verilog/mont_mult.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Word-serial MonPro engine
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module mont_mult #(
    parameter int NUM_WORDS = 2
) (
    input  logic      clk,
    input  logic      reset,
    mm_cmd_if.engine  cmd,
    operand_if.engine ops
);
    import mont_pkg::*;

    localparam int IDX_W = $clog2(NUM_WORDS);
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(NUM_WORDS - 1);

    localparam logic [2:0] PH_ACC = 3'd0;   // v += a_i * B
    localparam logic [2:0] PH_TOP = 3'd1;   // carry into v[s], v[s+1]
    localparam logic [2:0] PH_QUO = 3'd2;   // q = v0 * n'0 mod 2^w
    localparam logic [2:0] PH_RED = 3'd3;   // v = (v + q * N) >> w
    localparam logic [2:0] PH_FD1 = 3'd4;   // v[s-1] = v[s] + C
    localparam logic [2:0] PH_FD2 = 3'd5;   // v[s] = v[s+1] + C

    logic [WORD_WIDTH-1:0] v [NUM_WORDS+2];
    logic [WORD_WIDTH-1:0] carry;
    logic [WORD_WIDTH-1:0] q;
    logic                  busy;
    logic                  capture;         // second cycle of a step
    logic [2:0]            phase;
    logic [IDX_W-1:0]      i_idx;
    logic [IDX_W-1:0]      j_idx;
    logic [SEL_WIDTH-1:0]  a_sel_q;
    logic [SEL_WIDTH-1:0]  b_sel_q;
    logic [WORD_WIDTH-1:0] x;
    logic [WORD_WIDTH-1:0] y;
    logic [WORD_WIDTH-1:0] z;
    logic [WORD_WIDTH-1:0] c_in;
    logic                  last_iter;
    mul_add_result_u       res;

    mul_add_unit mul_add_i (
        .clk      (clk),
        .x        (x),
        .y        (y),
        .z        (z),
        .carry_in (c_in),
        .result   (res)
    );

    assign last_iter = (i_idx == LAST_IDX);

    assign ops.a_sel = a_sel_q;
    assign ops.b_sel = b_sel_q;
    assign ops.a_idx = i_idx;
    assign ops.b_idx = j_idx;
    assign ops.n_idx = j_idx;

    // result words leave while the last pass reduces, A and B are no longer read
    assign ops.wr_en   = busy && capture && last_iter &&
                         ((phase == PH_RED && j_idx != '0) || phase == PH_FD1);
    assign ops.wr_idx  = (phase == PH_FD1) ? LAST_IDX : j_idx - 1'b1;
    assign ops.wr_word = res.parts.sum;

    always_comb begin
        x    = '0;
        y    = '0;
        z    = '0;
        c_in = carry;
        case (phase)
            PH_ACC: begin
                x = ops.a_word;
                y = ops.b_word;
                z = v[j_idx];
                if (j_idx == '0) begin
                    c_in = '0;              // fresh carry each outer pass
                end
            end
            PH_TOP: z = v[NUM_WORDS];
            PH_QUO: begin
                x    = v[0];
                y    = ops.nprime0;
                c_in = '0;
            end
            PH_RED: begin
                x = q;
                y = ops.n_word;
                z = v[j_idx];
                if (j_idx == '0) begin
                    c_in = '0;
                end
            end
            PH_FD1:  z = v[NUM_WORDS];
            default: z = v[NUM_WORDS+1];
        endcase
    end

    always_ff @(posedge clk) begin
        if (!busy && cmd.start) begin
            a_sel_q <= cmd.a_sel;
            b_sel_q <= cmd.b_sel;
        end
        if (busy && capture && phase == PH_QUO) begin
            q <= res.parts.sum;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy     <= 1'b0;
            capture  <= 1'b0;
            phase    <= PH_ACC;
            i_idx    <= '0;
            j_idx    <= '0;
            carry    <= '0;
            cmd.done <= 1'b0;
            for (int k = 0; k < NUM_WORDS + 2; k++) begin
                v[k] <= '0;
            end
        end else begin
            cmd.done <= 1'b0;
            if (!busy) begin
                busy <= cmd.start;
            end else if (!capture) begin
                capture <= 1'b1;            // issue cycle, unit registers inputs
            end else begin
                capture <= 1'b0;
                case (phase)
                    PH_ACC, PH_RED: begin
                        if (phase == PH_ACC) begin
                            v[j_idx] <= res.parts.sum;
                        end else if (j_idx != '0) begin
                            v[j_idx - 1'b1] <= res.parts.sum;
                        end
                        carry <= res.parts.carry;
                        if (j_idx == LAST_IDX) begin
                            j_idx <= '0;
                            phase <= phase + 3'd1;
                        end else begin
                            j_idx <= j_idx + 1'b1;
                        end
                    end
                    PH_TOP: begin
                        v[NUM_WORDS]   <= res.parts.sum;
                        v[NUM_WORDS+1] <= res.parts.carry;
                        phase          <= PH_QUO;
                    end
                    PH_QUO: phase <= PH_RED;
                    PH_FD1: begin
                        v[NUM_WORDS-1] <= res.parts.sum;
                        carry          <= res.parts.carry;
                        phase          <= PH_FD2;
                    end
                    default: begin
                        v[NUM_WORDS] <= res.parts.sum;
                        phase        <= PH_ACC;
                        if (last_iter) begin
                            i_idx    <= '0;
                            busy     <= 1'b0;
                            cmd.done <= 1'b1;
                            carry    <= '0;
                            for (int k = 0; k < NUM_WORDS + 2; k++) begin
                                v[k] <= '0;   // ready for the next MonPro
                            end
                        end else begin
                            i_idx <= i_idx + 1'b1;
                        end
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/mod_exp_ctrl.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Exponentiation sequencer
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module mod_exp_ctrl #(
    parameter int NUM_WORDS = 2
) (
    input  logic                                              clk,
    input  logic                                              reset,
    input  logic                                              load_valid,
    output logic                                              load_ready,
    output logic                                              res_valid,
    input  logic                                              res_ready,
    output logic [mont_pkg::WORD_WIDTH-1:0]                   res_word,
    output logic                                              copy_r,
    output logic [$clog2(NUM_WORDS*mont_pkg::WORD_WIDTH)-1:0] e_bit_idx,
    input  logic                                              e_bit,
    mm_cmd_if.ctrl                                            cmd,
    input  logic [mont_pkg::WORD_WIDTH-1:0]                   c_bar_word,
    output logic [$clog2(NUM_WORDS)-1:0]                      res_idx
);
    import mont_pkg::*;

    localparam int IDX_W = $clog2(NUM_WORDS);
    localparam int BIT_W = $clog2(NUM_WORDS * WORD_WIDTH);
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(NUM_WORDS - 1);
    localparam logic [BIT_W-1:0] TOP_BIT  = BIT_W'(NUM_WORDS * WORD_WIDTH - 1);

    localparam logic [2:0] S_LOAD  = 3'd0;
    localparam logic [2:0] S_ISSUE = 3'd1;   // start pulse to the engine
    localparam logic [2:0] S_WAIT  = 3'd2;
    localparam logic [2:0] S_SCAN  = 3'd3;   // leading one search
    localparam logic [2:0] S_OUT   = 3'd4;

    localparam logic [1:0] OP_MBAR  = 2'd0;  // m_bar = MonPro(m, t)
    localparam logic [1:0] OP_SQR   = 2'd1;
    localparam logic [1:0] OP_MUL   = 2'd2;
    localparam logic [1:0] OP_FINAL = 2'd3;  // MonPro(1, c_bar)

    logic [2:0]       state;
    logic [1:0]       op;
    logic [IDX_W-1:0] load_idx;

    assign load_ready = (state == S_LOAD);
    assign res_valid  = (state == S_OUT);
    assign res_word   = c_bar_word;
    assign cmd.start  = (state == S_ISSUE);
    assign copy_r     = (state == S_ISSUE) && (op == OP_MBAR);

    always_comb begin
        case (op)
            OP_MBAR: begin
                cmd.a_sel = SEL_M_BAR;
                cmd.b_sel = SEL_T;
            end
            OP_SQR: begin
                cmd.a_sel = SEL_C_BAR;
                cmd.b_sel = SEL_C_BAR;
            end
            OP_MUL: begin
                cmd.a_sel = SEL_C_BAR;
                cmd.b_sel = SEL_M_BAR;
            end
            default: begin
                cmd.a_sel = SEL_ONE;
                cmd.b_sel = SEL_C_BAR;
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= S_LOAD;
            op        <= OP_MBAR;
            load_idx  <= '0;
            res_idx   <= '0;
            e_bit_idx <= TOP_BIT;
        end else begin
            case (state)
                S_LOAD: begin
                    if (load_valid) begin
                        load_idx <= (load_idx == LAST_IDX) ? '0 : load_idx + 1'b1;
                        if (load_idx == LAST_IDX) begin
                            op    <= OP_MBAR;
                            state <= S_ISSUE;
                        end
                    end
                end
                S_ISSUE: state <= S_WAIT;
                S_SCAN: begin
                    if (e_bit) begin
                        op    <= OP_SQR;
                        state <= S_ISSUE;
                    end else if (e_bit_idx == '0) begin
                        op    <= OP_FINAL;         // e is zero, result is 1
                        state <= S_ISSUE;
                    end else begin
                        e_bit_idx <= e_bit_idx - 1'b1;
                    end
                end
                S_WAIT: begin
                    if (cmd.done) begin
                        state <= S_ISSUE;
                        case (op)
                            OP_MBAR: begin
                                e_bit_idx <= TOP_BIT;
                                state     <= S_SCAN;
                            end
                            OP_SQR, OP_MUL: begin
                                if (op == OP_SQR && e_bit) begin
                                    op <= OP_MUL;
                                end else if (e_bit_idx == '0) begin
                                    op <= OP_FINAL;
                                end else begin
                                    e_bit_idx <= e_bit_idx - 1'b1;
                                    op        <= OP_SQR;
                                end
                            end
                            default: state <= S_OUT;
                        endcase
                    end
                end
                S_OUT: begin
                    if (res_ready) begin
                        res_idx <= (res_idx == LAST_IDX) ? '0 : res_idx + 1'b1;
                        if (res_idx == LAST_IDX) begin
                            state <= S_LOAD;
                        end
                    end
                end
                default: state <= S_LOAD;
            endcase
        end
    end

endmodule

`default_nettype wire

/* verilog/mod_exp.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Montgomery modular exponentiator top
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module mod_exp #(
    parameter int NUM_WORDS = 2
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            load_valid,
    output logic                            load_ready,
    input  logic [mont_pkg::WORD_WIDTH-1:0] m_word,
    input  logic [mont_pkg::WORD_WIDTH-1:0] e_word,
    input  logic [mont_pkg::WORD_WIDTH-1:0] n_word,
    input  logic [mont_pkg::WORD_WIDTH-1:0] r_word,
    input  logic [mont_pkg::WORD_WIDTH-1:0] t_word,
    input  logic [mont_pkg::WORD_WIDTH-1:0] nprime0,
    output logic                            res_valid,
    input  logic                            res_ready,
    output logic [mont_pkg::WORD_WIDTH-1:0] res_word
);
    import mont_pkg::*;

    logic                                    copy_r;
    logic [$clog2(NUM_WORDS*WORD_WIDTH)-1:0] e_bit_idx;
    logic                                    e_bit;
    logic [$clog2(NUM_WORDS)-1:0]            res_idx;
    logic [WORD_WIDTH-1:0]                   c_bar_word;

    mm_cmd_if                             cmd_if ();
    operand_if #(.NUM_WORDS(NUM_WORDS))   ops_if ();

    operand_store #(.NUM_WORDS(NUM_WORDS)) operand_store_i (
        .clk        (clk),
        .reset      (reset),
        .load_valid (load_valid),
        .load_ready (load_ready),
        .m_word     (m_word),
        .e_word     (e_word),
        .n_word     (n_word),
        .r_word     (r_word),
        .t_word     (t_word),
        .nprime0    (nprime0),
        .copy_r     (copy_r),
        .e_bit_idx  (e_bit_idx),
        .e_bit      (e_bit),
        .res_idx    (res_idx),
        .c_bar_word (c_bar_word),
        .ops        (ops_if.store)
    );

    mont_mult #(.NUM_WORDS(NUM_WORDS)) mont_mult_i (
        .clk   (clk),
        .reset (reset),
        .cmd   (cmd_if.engine),
        .ops   (ops_if.engine)
    );

    mod_exp_ctrl #(.NUM_WORDS(NUM_WORDS)) mod_exp_ctrl_i (
        .clk        (clk),
        .reset      (reset),
        .load_valid (load_valid),
        .load_ready (load_ready),
        .res_valid  (res_valid),
        .res_ready  (res_ready),
        .res_word   (res_word),
        .copy_r     (copy_r),
        .e_bit_idx  (e_bit_idx),
        .e_bit      (e_bit),
        .cmd        (cmd_if.ctrl),
        .c_bar_word (c_bar_word),
        .res_idx    (res_idx)
    );

endmodule

`default_nettype wire

/* dv/mod_exp_tb.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Modular exponentiator testbench
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module mod_exp_tb;
    import mont_pkg::*;

    localparam int NUM_WORDS   = 2;
    localparam int MOD_BITS    = NUM_WORDS * WORD_WIDTH;
    localparam int MAX_OPS     = 40;
    localparam int MAX_LATENCY = 64 * 2 * 97;   // bits x MonPros per bit x cycles
    localparam int CYCLE_LIMIT = MAX_OPS * MAX_LATENCY + 1000;

    logic                  clk;
    logic                  reset;
    logic                  load_valid;
    logic                  load_ready;
    logic [WORD_WIDTH-1:0] m_word;
    logic [WORD_WIDTH-1:0] e_word;
    logic [WORD_WIDTH-1:0] n_word;
    logic [WORD_WIDTH-1:0] r_word;
    logic [WORD_WIDTH-1:0] t_word;
    logic [WORD_WIDTH-1:0] nprime0;
    logic                  res_valid;
    logic                  res_ready;
    logic [WORD_WIDTH-1:0] res_word;

    integer seed;
    int     num_checks  = 0;
    int     num_errors  = 0;
    int     cycle_count = 0;

    mod_exp #(.NUM_WORDS(NUM_WORDS)) mod_exp_i (
        .clk        (clk),
        .reset      (reset),
        .load_valid (load_valid),
        .load_ready (load_ready),
        .m_word     (m_word),
        .e_word     (e_word),
        .n_word     (n_word),
        .r_word     (r_word),
        .t_word     (t_word),
        .nprime0    (nprime0),
        .res_valid  (res_valid),
        .res_ready  (res_ready),
        .res_word   (res_word)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Some tests failed");
            $finish;
        end
    end

    // square and multiply with products below 2^60
    function automatic logic [63:0] mod_pow(input logic [63:0] base,
                                            input logic [63:0] exp,
                                            input logic [63:0] n);
        logic [63:0] acc;
        logic [63:0] b;
        acc = 64'd1 % n;
        b   = base % n;
        for (int i = MOD_BITS - 1; i >= 0; i--) begin
            acc = (acc * acc) % n;
            if (exp[i]) begin
                acc = (acc * b) % n;
            end
        end
        return acc;
    endfunction

    // -n^-1 mod 2^w by Newton iteration
    function automatic logic [WORD_WIDTH-1:0] neg_inverse(input logic [63:0] n);
        logic [63:0] x;
        x = n;                          // good to 3 bits for odd n
        repeat (5) begin
            x = x * (64'd2 - n * x);
        end
        return WORD_WIDTH'(64'd0 - x);
    endfunction

    task automatic check_word(input string name, input logic [WORD_WIDTH-1:0] expected,
                              input logic [WORD_WIDTH-1:0] actual);
        num_checks++;
        if (actual !== expected) begin
            num_errors++;
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        num_checks++;
        if (actual !== expected) begin
            num_errors++;
            $display("FAILED %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    task automatic load_operands(input string name, input logic [63:0] m,
                                 input logic [63:0] e, input logic [63:0] n);
        logic [63:0]           r;
        logic [63:0]           t;
        logic [WORD_WIDTH-1:0] np;
        r  = (64'd1 << MOD_BITS) % n;
        t  = (r * r) % n;
        np = neg_inverse(n);
        while (!load_ready) @(negedge clk);
        for (int w = 0; w < NUM_WORDS; w++) begin
            load_valid = 1'b1;
            m_word     = m[w*WORD_WIDTH +: WORD_WIDTH];
            e_word     = e[w*WORD_WIDTH +: WORD_WIDTH];
            n_word     = n[w*WORD_WIDTH +: WORD_WIDTH];
            r_word     = r[w*WORD_WIDTH +: WORD_WIDTH];
            t_word     = t[w*WORD_WIDTH +: WORD_WIDTH];
            nprime0    = np;
            @(negedge clk);
        end
        load_valid = 1'b0;
        check_flag($sformatf("%s load_ready after last beat", name), 1'b0, load_ready);
    endtask

    task automatic collect_result(input string name, input logic [63:0] expected,
                                  input int stall);
        logic [WORD_WIDTH-1:0] held;
        for (int k = 0; k < NUM_WORDS; k++) begin
            while (!res_valid) begin
                check_flag($sformatf("%s load_ready while computing", name),
                           1'b0, load_ready);
                @(negedge clk);
            end
            if (k == 0 && stall > 0) begin
                held = res_word;
                repeat (stall) begin
                    @(negedge clk);
                    check_flag($sformatf("%s res_valid held", name), 1'b1, res_valid);
                    check_word($sformatf("%s res_word held", name), held, res_word);
                end
                res_ready = 1'b1;       // word goes on the next rising edge
            end
            check_flag($sformatf("%s load_ready busy", name), 1'b0, load_ready);
            check_word($sformatf("%s word %0d", name, k),
                       expected[k*WORD_WIDTH +: WORD_WIDTH], res_word);
            @(negedge clk);
        end
        check_flag($sformatf("%s load_ready after result", name), 1'b1, load_ready);
        check_flag($sformatf("%s res_valid after result", name), 1'b0, res_valid);
    endtask

    task automatic run_op(input string name, input logic [63:0] m, input logic [63:0] e,
                          input logic [63:0] n, input logic [63:0] expected, input int stall);
        res_ready = (stall == 0);
        load_operands(name, m, e, n);
        collect_result(name, expected, stall);
    endtask

    task automatic known_value();
        run_op("known value", 64'd4, 64'd13, 64'd497, mod_pow(64'd4, 64'd13, 64'd497), 0);
    endtask

    task automatic exponent_one_and_zero();
        run_op("exponent one", 64'h00bc_614e, 64'd1, 64'h2f00_0c35, 64'h00bc_614e, 0);
        run_op("exponent zero", 64'h00bc_614e, 64'd0, 64'h2f00_0c35, 64'd1, 0);
    endtask

    task automatic random_cases();
        logic [31:0] rnd;
        logic [63:0] n;
        logic [63:0] m;
        logic [63:0] e;
        for (int k = 0; k < 10; k++) begin
            rnd = $random(seed);
            n   = 64'(rnd & 32'h3fff_ffff) | 64'h8001;   // odd and below 2^30
            rnd = $random(seed);
            m   = 64'(rnd) % n;
            rnd = $random(seed);
            e   = 64'(rnd);
            run_op($sformatf("random %0d", k), m, e, n, mod_pow(m, e, n), 0);
        end
    endtask

    task automatic result_back_pressure();
        run_op("back pressure", 64'h0123_4567, 64'h8000_0005, 64'h3a5c_0e2b,
               mod_pow(64'h0123_4567, 64'h8000_0005, 64'h3a5c_0e2b), 6);
    endtask

    // second operation starts as soon as load_ready returns
    task automatic load_handshake();
        run_op("back to back a", 64'h0000_beef, 64'h0001_0003, 64'h1fff_ffd9,
               mod_pow(64'h0000_beef, 64'h0001_0003, 64'h1fff_ffd9), 0);
        run_op("back to back b", 64'h1234_0001, 64'hffff_ffff, 64'h3000_0007,
               mod_pow(64'h1234_0001, 64'hffff_ffff, 64'h3000_0007), 0);
    endtask

    initial begin
        seed       = 32'hf0dc_2042;
        reset      = 1'b1;
        load_valid = 1'b0;
        m_word     = '0;
        e_word     = '0;
        n_word     = '0;
        r_word     = '0;
        t_word     = '0;
        nprime0    = '0;
        res_ready  = 1'b1;
        repeat (2) @(negedge clk);
        reset = 1'b0;
        check_flag("reset load_ready", 1'b1, load_ready);
        check_flag("reset res_valid", 1'b0, res_valid);
        known_value();
        exponent_one_and_zero();
        random_cases();
        result_back_pressure();
        load_handshake();
        $display("checks: %0d, errors: %0d", num_checks, num_errors);
        if (num_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
verilog/mont_pkg.sv
verilog/mont_ifs.sv
verilog/mul_add_unit.sv
verilog/operand_store.sv
verilog/mont_mult.sv
verilog/mod_exp_ctrl.sv
verilog/mod_exp.sv
dv/mod_exp_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the mod_exp testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module mod_exp_tb -f project.f \
    -Mdir obj_dir > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/Vmod_exp_tb > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Some tests failed" sim.log; then
    exit 1
fi
exit 0
